// File: logic/mesh_defines.svh
`ifndef MESH_DEFINES_SVH
`define MESH_DEFINES_SVH

// Matrix dimension N that the tile size must divide
`define MESH_MATRIX_SIZE 4
// Tile dimension T
`define MESH_TILE_SIZE 2
`define MESH_DATA_WIDTH 32

// Derived counts
`define MESH_NUM_TILES (`MESH_MATRIX_SIZE / `MESH_TILE_SIZE)
`define MESH_MEM_DEPTH (`MESH_MATRIX_SIZE * `MESH_MATRIX_SIZE)
`define MESH_ADDR_WIDTH $clog2(`MESH_MEM_DEPTH)

`endif

// File: logic/mesh_pkg.sv
package mesh_pkg;

`include "mesh_defines.svh"

    typedef logic [`MESH_DATA_WIDTH-1:0] data_t;

    // Row-major element address and fill count of one matrix store
    typedef logic [`MESH_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`MESH_ADDR_WIDTH:0]   fill_t;

    // Tile and element indices never narrower than one bit
    typedef logic [(`MESH_NUM_TILES > 1 ? $clog2(`MESH_NUM_TILES) : 1)-1:0] tile_idx_t;
    typedef logic [(`MESH_TILE_SIZE > 1 ? $clog2(`MESH_TILE_SIZE) : 1)-1:0] elem_idx_t;

    typedef enum logic {
        SCHED_IDLE,
        SCHED_ISSUE
    } sched_state_t;

endpackage

// File: logic/operand_store.sv
`timescale 1ns/1ps

`include "mesh_defines.svh"

module operand_store (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                wr_en_i,
    input  mesh_pkg::data_t     wr_data_i,
    input  logic                wr_reset_i,
    input  logic                rd_en_i,
    input  mesh_pkg::mem_addr_t rd_addr_i,
    output mesh_pkg::data_t     rd_data_o,
    output logic                empty_o,
    output logic                full_o
);

    mesh_pkg::data_t     mem [`MESH_MEM_DEPTH];
    mesh_pkg::mem_addr_t wr_ptr;
    mesh_pkg::fill_t     fill_cnt;
    logic                wr_accept;

    // Write reset wins over a write and a full store drops writes
    assign wr_accept = wr_en_i && !full_o && !wr_reset_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr   <= '0;
            fill_cnt <= '0;
        end else if (wr_reset_i) begin
            wr_ptr   <= '0;
            fill_cnt <= '0;
        end else if (wr_accept) begin
            wr_ptr   <= wr_ptr + 1'b1;
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // Registered read port
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    assign empty_o = (fill_cnt == 0);
    assign full_o  = (fill_cnt == `MESH_MEM_DEPTH);

endmodule

// File: logic/block_scheduler.sv
`timescale 1ns/1ps

`include "mesh_defines.svh"

module block_scheduler (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                start_i,
    input  logic                a_full_i,
    input  logic                b_full_i,
    output logic                clear_o,
    output logic                rd_en_o,
    output mesh_pkg::mem_addr_t a_addr_o,
    output mesh_pkg::mem_addr_t b_addr_o,
    output mesh_pkg::mem_addr_t c_addr_o,
    output logic                first_m_o,
    output logic                last_m_o,
    output logic                first_k_o,
    output logic                last_beat_o,
    output logic                alloc_done_o
);

    mesh_pkg::sched_state_t state_q;
    mesh_pkg::tile_idx_t    i_q, j_q, k_q;
    mesh_pkg::elem_idx_t    r_q, c_q, m_q;
    logic start_ok;
    logic issue;
    logic i_last, j_last, k_last;
    logic r_last, c_last, m_last;
    logic final_beat;

    function automatic mesh_pkg::mem_addr_t rm_addr(input int unsigned row,
                                                    input int unsigned col);
        int unsigned flat;
        flat = row * `MESH_MATRIX_SIZE + col;
        return mesh_pkg::mem_addr_t'(flat);
    endfunction

    assign start_ok = (state_q == mesh_pkg::SCHED_IDLE) && start_i && a_full_i && b_full_i;
    assign issue    = (state_q == mesh_pkg::SCHED_ISSUE);

    assign i_last = (i_q == `MESH_NUM_TILES - 1);
    assign j_last = (j_q == `MESH_NUM_TILES - 1);
    assign k_last = (k_q == `MESH_NUM_TILES - 1);
    assign r_last = (r_q == `MESH_TILE_SIZE - 1);
    assign c_last = (c_q == `MESH_TILE_SIZE - 1);
    assign m_last = (m_q == `MESH_TILE_SIZE - 1);
    assign final_beat = i_last && j_last && k_last && r_last && c_last && m_last;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= mesh_pkg::SCHED_IDLE;
        end else if (start_ok) begin
            state_q <= mesh_pkg::SCHED_ISSUE;
        end else if (issue && final_beat) begin
            state_q <= mesh_pkg::SCHED_IDLE;
        end
    end

    // Loop nest i, j, k, r, c, m with m innermost
    // All counters wrap back to zero on the final beat
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            i_q <= '0;
            j_q <= '0;
            k_q <= '0;
            r_q <= '0;
            c_q <= '0;
            m_q <= '0;
        end else if (issue) begin
            m_q <= m_last ? '0 : m_q + 1'b1;
            if (m_last) begin
                c_q <= c_last ? '0 : c_q + 1'b1;
                if (c_last) begin
                    r_q <= r_last ? '0 : r_q + 1'b1;
                    if (r_last) begin
                        k_q <= k_last ? '0 : k_q + 1'b1;
                        if (k_last) begin
                            j_q <= j_last ? '0 : j_q + 1'b1;
                            if (j_last) begin
                                i_q <= i_last ? '0 : i_q + 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            clear_o      <= 1'b0;
            rd_en_o      <= 1'b0;
            last_beat_o  <= 1'b0;
            alloc_done_o <= 1'b0;
        end else begin
            clear_o     <= start_ok;
            rd_en_o     <= issue;
            last_beat_o <= issue && final_beat;
            // Raised the cycle after the last beat leaves
            if (start_ok) begin
                alloc_done_o <= 1'b0;
            end else if (last_beat_o) begin
                alloc_done_o <= 1'b1;
            end
        end
    end

    // Beat payload qualified by rd_en_o downstream
    always_ff @(posedge clk_i) begin
        a_addr_o  <= rm_addr(i_q * `MESH_TILE_SIZE + r_q, k_q * `MESH_TILE_SIZE + m_q);
        b_addr_o  <= rm_addr(k_q * `MESH_TILE_SIZE + m_q, j_q * `MESH_TILE_SIZE + c_q);
        c_addr_o  <= rm_addr(i_q * `MESH_TILE_SIZE + r_q, j_q * `MESH_TILE_SIZE + c_q);
        first_m_o <= (m_q == 0);
        last_m_o  <= m_last;
        first_k_o <= (k_q == 0);
    end

endmodule

// File: logic/tile_mac.sv
`timescale 1ns/1ps

module tile_mac (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                valid_i,
    input  mesh_pkg::data_t     a_i,
    input  mesh_pkg::data_t     b_i,
    input  mesh_pkg::mem_addr_t c_addr_i,
    input  logic                first_m_i,
    input  logic                last_m_i,
    input  logic                first_k_i,
    input  logic                last_beat_i,
    output logic                sum_valid_o,
    output mesh_pkg::data_t     sum_o,
    output mesh_pkg::mem_addr_t sum_addr_o,
    output logic                sum_first_k_o,
    output logic                sum_last_o
);

    logic                valid_q;
    mesh_pkg::mem_addr_t c_addr_q;
    logic                first_m_q, last_m_q, first_k_q, last_beat_q;
    mesh_pkg::data_t     product;
    mesh_pkg::data_t     acc_q;
    mesh_pkg::data_t     acc_next;

    // Tags wait one cycle for the store read data
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        c_addr_q    <= c_addr_i;
        first_m_q   <= first_m_i;
        last_m_q    <= last_m_i;
        first_k_q   <= first_k_i;
        last_beat_q <= last_beat_i;
    end

    // Product wraps to the data width
    assign product  = a_i * b_i;
    assign acc_next = first_m_q ? product : acc_q + product;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= valid_q && last_m_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_q) begin
            acc_q <= acc_next;
        end
        if (valid_q && last_m_q) begin
            sum_o         <= acc_next;
            sum_addr_o    <= c_addr_q;
            sum_first_k_o <= first_k_q;
            sum_last_o    <= last_beat_q;
        end
    end

endmodule

// File: logic/result_store.sv
`timescale 1ns/1ps

`include "mesh_defines.svh"

module result_store (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                clear_i,
    input  logic                sum_valid_i,
    input  mesh_pkg::data_t     sum_i,
    input  mesh_pkg::mem_addr_t sum_addr_i,
    input  logic                sum_first_k_i,
    input  logic                sum_last_i,
    input  mesh_pkg::mem_addr_t rd_addr_i,
    output mesh_pkg::data_t     rd_data_o,
    output logic                done_o
);

    mesh_pkg::data_t c_mem [`MESH_MEM_DEPTH];

    // First k overwrites and later k add onto the stored partial sum
    always_ff @(posedge clk_i) begin
        if (sum_valid_i) begin
            c_mem[sum_addr_i] <= sum_first_k_i ? sum_i : c_mem[sum_addr_i] + sum_i;
        end
        rd_data_o <= c_mem[rd_addr_i];
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_o <= 1'b0;
        end else if (clear_i) begin
            done_o <= 1'b0;
        end else if (sum_valid_i && sum_last_i) begin
            done_o <= 1'b1;
        end
    end

endmodule

// File: logic/block_matmul_top.sv
`timescale 1ns/1ps

module block_matmul_top (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                start_i,
    input  logic                north_wr_en_i,
    input  mesh_pkg::data_t     north_wr_data_i,
    input  logic                north_wr_reset_i,
    input  logic                west_wr_en_i,
    input  mesh_pkg::data_t     west_wr_data_i,
    input  logic                west_wr_reset_i,
    input  mesh_pkg::mem_addr_t result_addr_i,
    output logic                north_empty_o,
    output logic                west_empty_o,
    output logic                alloc_done_o,
    output logic                mult_done_o,
    output mesh_pkg::data_t     result_data_o
);

    logic                a_full, b_full;
    logic                clear;
    logic                rd_en;
    mesh_pkg::mem_addr_t a_addr, b_addr, c_addr;
    logic                first_m, last_m, first_k, last_beat;
    mesh_pkg::data_t     a_data, b_data;
    logic                sum_valid;
    mesh_pkg::data_t     sum;
    mesh_pkg::mem_addr_t sum_addr;
    logic                sum_first_k, sum_last;

    // Matrix A
    operand_store west_store (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_en_i    (west_wr_en_i),
        .wr_data_i  (west_wr_data_i),
        .wr_reset_i (west_wr_reset_i),
        .rd_en_i    (rd_en),
        .rd_addr_i  (a_addr),
        .rd_data_o  (a_data),
        .empty_o    (west_empty_o),
        .full_o     (a_full)
    );

    // Matrix B
    operand_store north_store (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_en_i    (north_wr_en_i),
        .wr_data_i  (north_wr_data_i),
        .wr_reset_i (north_wr_reset_i),
        .rd_en_i    (rd_en),
        .rd_addr_i  (b_addr),
        .rd_data_o  (b_data),
        .empty_o    (north_empty_o),
        .full_o     (b_full)
    );

    block_scheduler u_sched (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .start_i      (start_i),
        .a_full_i     (a_full),
        .b_full_i     (b_full),
        .clear_o      (clear),
        .rd_en_o      (rd_en),
        .a_addr_o     (a_addr),
        .b_addr_o     (b_addr),
        .c_addr_o     (c_addr),
        .first_m_o    (first_m),
        .last_m_o     (last_m),
        .first_k_o    (first_k),
        .last_beat_o  (last_beat),
        .alloc_done_o (alloc_done_o)
    );

    tile_mac u_mac (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .valid_i       (rd_en),
        .a_i           (a_data),
        .b_i           (b_data),
        .c_addr_i      (c_addr),
        .first_m_i     (first_m),
        .last_m_i      (last_m),
        .first_k_i     (first_k),
        .last_beat_i   (last_beat),
        .sum_valid_o   (sum_valid),
        .sum_o         (sum),
        .sum_addr_o    (sum_addr),
        .sum_first_k_o (sum_first_k),
        .sum_last_o    (sum_last)
    );

    result_store u_result (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .clear_i       (clear),
        .sum_valid_i   (sum_valid),
        .sum_i         (sum),
        .sum_addr_i    (sum_addr),
        .sum_first_k_i (sum_first_k),
        .sum_last_i    (sum_last),
        .rd_addr_i     (result_addr_i),
        .rd_data_o     (result_data_o),
        .done_o        (mult_done_o)
    );

endmodule

// File: sim/block_matmul_tb.sv
`timescale 1ns/1ps

`include "mesh_defines.svh"

module block_matmul_tb;

    localparam int    MEM_DEPTH     = `MESH_MEM_DEPTH;
    localparam int    NUM_VECTORS   = 2 * MEM_DEPTH;
    localparam string VEC_FILE      = "sim/block_matmul_input.txt";
    localparam int    DRIVE_DELAY   = 2;
    localparam int    CLEAR_TIMEOUT = 5;
    localparam int    DONE_TIMEOUT  = MEM_DEPTH * `MESH_MATRIX_SIZE + 20;

    logic                clk_i;
    logic                rstn_i;
    logic                start_i;
    logic                north_wr_en_i;
    mesh_pkg::data_t     north_wr_data_i;
    logic                north_wr_reset_i;
    logic                west_wr_en_i;
    mesh_pkg::data_t     west_wr_data_i;
    logic                west_wr_reset_i;
    mesh_pkg::mem_addr_t result_addr_i;
    logic                north_empty_o;
    logic                west_empty_o;
    logic                alloc_done_o;
    logic                mult_done_o;
    mesh_pkg::data_t     result_data_o;

    // Vectors from the data file with set 0 ahead of set 1
    mesh_pkg::data_t a_vec [NUM_VECTORS];
    mesh_pkg::data_t b_vec [NUM_VECTORS];
    mesh_pkg::data_t c_vec [NUM_VECTORS];

    block_matmul_top dut0 (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .start_i          (start_i),
        .north_wr_en_i    (north_wr_en_i),
        .north_wr_data_i  (north_wr_data_i),
        .north_wr_reset_i (north_wr_reset_i),
        .west_wr_en_i     (west_wr_en_i),
        .west_wr_data_i   (west_wr_data_i),
        .west_wr_reset_i  (west_wr_reset_i),
        .result_addr_i    (result_addr_i),
        .north_empty_o    (north_empty_o),
        .west_empty_o     (west_empty_o),
        .alloc_done_o     (alloc_done_o),
        .mult_done_o      (mult_done_o),
        .result_data_o    (result_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input mesh_pkg::data_t got,
                               input mesh_pkg::data_t expected);
        if (got !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    // Inputs change a short delay after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic load_vectors();
        int              fd;
        int              n_items;
        int              value;
        int              count;
        int              idx;
        string           line;
        mesh_pkg::data_t a_val;
        mesh_pkg::data_t b_val;
        mesh_pkg::data_t c_val;
        count = -1;
        idx   = 0;
        fd    = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VEC_FILE);
            stop_with_failure();
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comment lines
            if (line.len() > 0 && line.getc(0) != "/") begin
                if (count < 0) begin
                    n_items = $sscanf(line, "%d", value);
                    if (n_items == 1) begin
                        count = value;
                    end
                end else begin
                    n_items = $sscanf(line, "%h %h %h", a_val, b_val, c_val);
                    if (n_items == 3 && idx < NUM_VECTORS) begin
                        a_vec[idx] = a_val;
                        b_vec[idx] = b_val;
                        c_vec[idx] = c_val;
                        idx++;
                    end
                end
            end
        end
        $fclose(fd);
        if (count != NUM_VECTORS || idx != NUM_VECTORS) begin
            $display("the vector file holds %0d vectors, %0d were expected", idx, NUM_VECTORS);
            stop_with_failure();
        end
    endtask

    task automatic write_element(input bit to_north, input mesh_pkg::data_t value);
        if (to_north) begin
            north_wr_en_i   = 1'b1;
            north_wr_data_i = value;
        end else begin
            west_wr_en_i   = 1'b1;
            west_wr_data_i = value;
        end
        next_cycle();
        north_wr_en_i = 1'b0;
        west_wr_en_i  = 1'b0;
    endtask

    task automatic run_multiply();
        int cycles;
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        // A done flag left from the previous run drops once the clear arrives
        cycles = 0;
        while (mult_done_o && cycles < CLEAR_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (mult_done_o) begin
            $display("mult_done_o stayed high after an accepted start");
            stop_with_failure();
        end
        cycles = 0;
        while (!mult_done_o && cycles < DONE_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!mult_done_o) begin
            $display("timed out waiting for mult_done_o");
            stop_with_failure();
        end
        check_value("alloc_done_o at mult_done_o", alloc_done_o, 1);
    endtask

    task automatic check_results(input int base, input string label);
        for (int addr = 0; addr < MEM_DEPTH; addr++) begin
            result_addr_i = mesh_pkg::mem_addr_t'(addr);
            next_cycle();
            check_value($sformatf("%s C[%0d]", label, addr), result_data_o, c_vec[base + addr]);
        end
    endtask

    initial begin
        rstn_i           = 1'b0;
        start_i          = 1'b0;
        north_wr_en_i    = 1'b0;
        north_wr_data_i  = '0;
        north_wr_reset_i = 1'b0;
        west_wr_en_i     = 1'b0;
        west_wr_data_i   = '0;
        west_wr_reset_i  = 1'b0;
        result_addr_i    = '0;

        load_vectors();

        repeat (5) @(posedge clk_i);
        #DRIVE_DELAY;
        rstn_i = 1'b1;
        next_cycle();

        // Idle state after reset
        check_value("north_empty_o after reset", north_empty_o, 1);
        check_value("west_empty_o after reset", west_empty_o, 1);
        check_value("alloc_done_o after reset", alloc_done_o, 0);
        check_value("mult_done_o after reset", mult_done_o, 0);

        // First write to each store clears its empty flag
        write_element(1'b0, a_vec[0]);
        check_value("west_empty_o after first write", west_empty_o, 0);
        check_value("north_empty_o before its first write", north_empty_o, 1);
        write_element(1'b1, b_vec[0]);
        check_value("north_empty_o after first write", north_empty_o, 0);

        // Start with B one element short must be ignored
        for (int n = 1; n < MEM_DEPTH; n++) begin
            write_element(1'b0, a_vec[n]);
        end
        for (int n = 1; n < MEM_DEPTH - 1; n++) begin
            write_element(1'b1, b_vec[n]);
        end
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        repeat (100) next_cycle();
        check_value("alloc_done_o after early start", alloc_done_o, 0);
        check_value("mult_done_o after early start", mult_done_o, 0);
        write_element(1'b1, b_vec[MEM_DEPTH - 1]);

        // First product
        run_multiply();
        check_results(0, "set 0");

        // Writes into full stores are dropped
        write_element(1'b0, 32'hdead_beef);
        write_element(1'b1, 32'h1234_5678);
        run_multiply();
        check_results(0, "set 0 rerun");

        // Empty both stores and compute the second set
        north_wr_reset_i = 1'b1;
        west_wr_reset_i  = 1'b1;
        next_cycle();
        north_wr_reset_i = 1'b0;
        west_wr_reset_i  = 1'b0;
        check_value("north_empty_o after write reset", north_empty_o, 1);
        check_value("west_empty_o after write reset", west_empty_o, 1);
        for (int n = 0; n < MEM_DEPTH; n++) begin
            write_element(1'b0, a_vec[MEM_DEPTH + n]);
            write_element(1'b1, b_vec[MEM_DEPTH + n]);
        end
        run_multiply();
        check_results(MEM_DEPTH, "set 1");

        $display("all tests passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
logic/mesh_pkg.sv
logic/operand_store.sv
logic/block_scheduler.sv
logic/tile_mac.sv
logic/result_store.sv
logic/block_matmul_top.sv
sim/block_matmul_tb.sv

// File: sim/block_matmul_input.txt
// First line is the vector count, then one line per row-major element
// Columns in hex are A element, B element and expected C element
32
1 2 5
2 0 6
3 1 7
4 0 a
5 0 11
6 1 e
7 0 13
8 3 1a
9 1 1d
a 0 16
b 2 1f
c 0 2a
d 0 29
e 1 1e
f 0 2b
10 1 3a
ffffffff 2 20
1 1 ffffffff
0 0 0
2 0 3
0 2 0
80000000 0 0
1 0 3
0 1 7fffffff
3 0 16
0 0 3
ffffffff 3 fffffffd
1 ffffffff 2
1 10 14
1 0 1
1 0 3
1 1 1
